// ==== hw/ccu_settings.svh ====
`ifndef CCU_SETTINGS_SVH
`define CCU_SETTINGS_SVH

// Port arrangement
`define CCU_NUM_PORTS       4
`define CCU_PORTS_PER_GROUP 2
`define CCU_NUM_GROUPS      (`CCU_NUM_PORTS / `CCU_PORTS_PER_GROUP)

// Bus widths
`define CCU_ADDR_W 32
`define CCU_DATA_W 32
`define CCU_ID_W   4

// Conflict monitor line address
`define CCU_LINE_OFFSET 4
`define CCU_CM_ADDR_W   12

`define CCU_TRACK_DEPTH 4

`endif

// ==== hw/ccu_txn_pkg.sv ====
`include "ccu_settings.svh"

package ccu_txn_pkg;

  typedef logic [`CCU_ADDR_W-1:0]    addr_t;
  typedef logic [`CCU_DATA_W-1:0]    data_t;
  typedef logic [`CCU_ID_W-1:0]      cache_id_t;
  // {port in group, cache id}
  typedef logic [`CCU_ID_W:0]        grp_id_t;
  // {snoop flag, group, grp id}
  typedef logic [`CCU_ID_W+2:0]      mem_id_t;
  typedef logic [`CCU_CM_ADDR_W-1:0] cm_addr_t;

  // Upper half of the encoding is snooping
  typedef enum logic [1:0] {
    OP_READ_NOSNOOP  = 2'b00,
    OP_WRITE_NOSNOOP = 2'b01,
    OP_READ_SHARED   = 2'b10,
    OP_WRITE_UNIQUE  = 2'b11
  } ccu_op_e;

endpackage

// ==== hw/ccu_link_pkg.sv ====
package ccu_link_pkg;

  import ccu_txn_pkg::*;

  // Cache side
  typedef struct packed {
    ccu_op_e   op;
    addr_t     addr;
    cache_id_t id;
    data_t     wdata;
  } cache_req_t;

  typedef struct packed {
    cache_id_t id;
    data_t     rdata;
  } cache_rsp_t;

  // Inside a group, id carries the port in group
  typedef struct packed {
    ccu_op_e op;
    addr_t   addr;
    grp_id_t id;
    data_t   wdata;
  } grp_req_t;

  // Memory side
  typedef struct packed {
    logic    write;
    addr_t   addr;
    mem_id_t id;
    data_t   wdata;
  } mem_req_t;

  typedef struct packed {
    mem_id_t id;
    data_t   rdata;
  } mem_rsp_t;

endpackage

// ==== hw/ccu_port_router.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module ccu_port_router (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                     [`CCU_NUM_PORTS-1:0]    req_valid_i,
  input  ccu_link_pkg::cache_req_t [`CCU_NUM_PORTS-1:0]    req_i,
  output logic                     [`CCU_NUM_PORTS-1:0]    req_ready_o,
  output logic                     [`CCU_NUM_GROUPS-1:0]   nsnp_valid_o,
  output ccu_link_pkg::grp_req_t   [`CCU_NUM_GROUPS-1:0]   nsnp_o,
  input  logic                     [`CCU_NUM_GROUPS-1:0]   nsnp_ready_i,
  output logic                     [`CCU_NUM_GROUPS-1:0]   snp_valid_o,
  output ccu_link_pkg::grp_req_t   [`CCU_NUM_GROUPS-1:0]   snp_o,
  input  logic                     [`CCU_NUM_GROUPS-1:0]   snp_ready_i
);
  import ccu_txn_pkg::*;
  import ccu_link_pkg::*;

  localparam int NG    = `CCU_NUM_GROUPS;
  localparam int PPG   = `CCU_PORTS_PER_GROUP;
  localparam int PIG_W = $clog2(PPG);

  typedef logic [PIG_W-1:0] pig_t;

  // Stream index 0 is non-snooping, 1 is snooping
  logic     [`CCU_NUM_PORTS-1:0] is_snp;
  logic     [NG-1:0][1:0]        vld_q;
  grp_req_t [NG-1:0][1:0]        data_q;
  pig_t     [NG-1:0][1:0]        ptr_q;
  pig_t     [NG-1:0][1:0]        win;
  logic     [NG-1:0][1:0]        found;
  logic     [NG-1:0][1:0]        take;
  logic     [NG-1:0][1:0]        down_ready;
  grp_req_t [NG-1:0][1:0]        cand;

  always_comb begin
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      is_snp[p] = req_i[p].op inside {OP_READ_SHARED, OP_WRITE_UNIQUE};
    end
  end

  ////////////////////////////////////////////////////////////
  // Round-robin per group and stream
  ////////////////////////////////////////////////////////////

  always_comb begin
    int p;
    p           = 0;
    req_ready_o = '0;
    for (int g = 0; g < NG; g++) begin
      for (int k = 0; k < 2; k++) begin
        found[g][k] = 1'b0;
        win[g][k]   = '0;
        for (int i = 0; i < PPG; i++) begin
          p = g * PPG + (int'(ptr_q[g][k]) + i) % PPG;
          if (!found[g][k] && req_valid_i[p] && (is_snp[p] == 1'(k))) begin
            found[g][k] = 1'b1;
            win[g][k]   = pig_t'(p - g * PPG);
          end
        end
        // Winner moves on when the register is empty or drains
        take[g][k] = found[g][k] && (!vld_q[g][k] || down_ready[g][k]);
        p = g * PPG + int'(win[g][k]);
        if (take[g][k]) begin
          req_ready_o[p] = 1'b1;
        end
        cand[g][k].op    = req_i[p].op;
        cand[g][k].addr  = req_i[p].addr;
        cand[g][k].id    = {win[g][k], req_i[p].id};
        cand[g][k].wdata = req_i[p].wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vld_q <= '0;
      ptr_q <= '0;
    end else begin
      for (int g = 0; g < NG; g++) begin
        for (int k = 0; k < 2; k++) begin
          if (take[g][k]) begin
            vld_q[g][k] <= 1'b1;
            ptr_q[g][k] <= pig_t'((int'(win[g][k]) + 1) % PPG);
          end else if (down_ready[g][k]) begin
            vld_q[g][k] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int g = 0; g < NG; g++) begin
      for (int k = 0; k < 2; k++) begin
        if (take[g][k]) begin
          data_q[g][k] <= cand[g][k];
        end
      end
    end
  end

  for (genvar g = 0; g < NG; g++) begin : gen_out
    assign down_ready[g]   = {snp_ready_i[g], nsnp_ready_i[g]};
    assign nsnp_valid_o[g] = vld_q[g][0];
    assign nsnp_o[g]       = data_q[g][0];
    assign snp_valid_o[g]  = vld_q[g][1];
    assign snp_o[g]        = data_q[g][1];
  end

endmodule

// ==== hw/ccu_snoop_tracker.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module ccu_snoop_tracker (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   in_valid_i,
  input  ccu_link_pkg::grp_req_t in_i,
  output logic                   in_ready_o,
  output logic                   out_valid_o,
  output ccu_link_pkg::grp_req_t out_o,
  input  logic                   out_ready_i,
  input  logic                   done_i,
  input  ccu_txn_pkg::grp_id_t   done_id_i,
  output logic                   cm_req_o,
  output ccu_txn_pkg::cm_addr_t  cm_addr_o
);
  import ccu_txn_pkg::*;
  import ccu_link_pkg::*;

  localparam int DEPTH = `CCU_TRACK_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  typedef logic [IDX_W-1:0] slot_idx_t;

  // Outstanding line table
  logic      [DEPTH-1:0] slot_vld_q;
  grp_id_t   [DEPTH-1:0] slot_id_q;
  cm_addr_t  [DEPTH-1:0] slot_addr_q;

  logic      out_vld_q;
  grp_req_t  out_q;
  logic      cm_req_q;
  cm_addr_t  cm_addr_q;

  logic      free_found;
  logic      hit_found;
  slot_idx_t free_idx;
  slot_idx_t hit_idx;
  logic      load;
  logic      drop;

  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    hit_found  = 1'b0;
    hit_idx    = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (!free_found && !slot_vld_q[i]) begin
        free_found = 1'b1;
        free_idx   = slot_idx_t'(i);
      end
      if (!hit_found && slot_vld_q[i] && (slot_id_q[i] == done_id_i)) begin
        hit_found = 1'b1;
        hit_idx   = slot_idx_t'(i);
      end
    end
  end

  assign in_ready_o = free_found && (!out_vld_q || out_ready_i);
  assign load       = in_valid_i && in_ready_o;
  assign drop       = done_i && hit_found;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      slot_vld_q <= '0;
      out_vld_q  <= 1'b0;
      cm_req_q   <= 1'b0;
    end else begin
      if (load) begin
        out_vld_q            <= 1'b1;
        slot_vld_q[free_idx] <= 1'b1;
      end else if (out_ready_i) begin
        out_vld_q <= 1'b0;
      end
      // Never the slot being filled
      if (drop) begin
        slot_vld_q[hit_idx] <= 1'b0;
      end
      cm_req_q <= drop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_q                 <= in_i;
      slot_id_q[free_idx]   <= in_i.id;
      slot_addr_q[free_idx] <= in_i.addr[`CCU_LINE_OFFSET +: `CCU_CM_ADDR_W];
    end
    if (drop) begin
      cm_addr_q <= slot_addr_q[hit_idx];
    end
  end

  assign out_valid_o = out_vld_q;
  assign out_o       = out_q;
  assign cm_req_o    = cm_req_q;
  assign cm_addr_o   = cm_addr_q;

endmodule

// ==== hw/ccu_mem_arbiter.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module ccu_mem_arbiter (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic                     [`CCU_NUM_GROUPS-1:0] nsnp_valid_i,
  input  ccu_link_pkg::grp_req_t   [`CCU_NUM_GROUPS-1:0] nsnp_i,
  output logic                     [`CCU_NUM_GROUPS-1:0] nsnp_ready_o,
  input  logic                     [`CCU_NUM_GROUPS-1:0] snp_valid_i,
  input  ccu_link_pkg::grp_req_t   [`CCU_NUM_GROUPS-1:0] snp_i,
  output logic                     [`CCU_NUM_GROUPS-1:0] snp_ready_o,
  output logic                                           mem_req_valid_o,
  output ccu_link_pkg::mem_req_t                         mem_req_o,
  input  logic                                           mem_req_ready_i,
  input  logic                                           mem_rsp_valid_i,
  input  ccu_link_pkg::mem_rsp_t                         mem_rsp_i,
  output logic                                           mem_rsp_ready_o,
  output logic                     [`CCU_NUM_PORTS-1:0]  rsp_valid_o,
  output ccu_link_pkg::cache_rsp_t [`CCU_NUM_PORTS-1:0]  rsp_o,
  input  logic                     [`CCU_NUM_PORTS-1:0]  rsp_ready_i,
  output logic                     [`CCU_NUM_GROUPS-1:0] done_o,
  output ccu_txn_pkg::grp_id_t                           done_id_o
);
  import ccu_txn_pkg::*;
  import ccu_link_pkg::*;

  localparam int NG      = `CCU_NUM_GROUPS;
  localparam int NI      = 2 * NG;
  localparam int PTR_W   = $clog2(NI);
  localparam int PORT_W  = $clog2(`CCU_NUM_PORTS);
  // Field positions in mem_id_t
  localparam int PIG_BIT = `CCU_ID_W;
  localparam int GRP_BIT = `CCU_ID_W + 1;
  localparam int SNP_BIT = `CCU_ID_W + 2;

  logic     [NI-1:0]    in_vld;
  logic     [NI-1:0]    in_rdy;
  grp_req_t [NI-1:0]    in_req;
  logic     [PTR_W-1:0] ptr_q;
  logic     [PTR_W-1:0] win;
  logic                 found;
  logic                 take;
  logic                 vld_q;
  mem_req_t             req_q;
  mem_req_t             cand;
  logic     [PORT_W-1:0] rsp_port;

  // Input 2g is non-snooping, 2g+1 snooping
  for (genvar g = 0; g < NG; g++) begin : gen_in
    assign in_vld[2*g]     = nsnp_valid_i[g];
    assign in_vld[2*g+1]   = snp_valid_i[g];
    assign in_req[2*g]     = nsnp_i[g];
    assign in_req[2*g+1]   = snp_i[g];
    assign nsnp_ready_o[g] = in_rdy[2*g];
    assign snp_ready_o[g]  = in_rdy[2*g+1];
  end

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  always_comb begin
    int idx;
    idx   = 0;
    found = 1'b0;
    win   = '0;
    for (int i = 0; i < NI; i++) begin
      idx = (int'(ptr_q) + i) % NI;
      if (!found && in_vld[idx]) begin
        found = 1'b1;
        win   = PTR_W'(idx);
      end
    end
    take   = found && (!vld_q || mem_req_ready_i);
    in_rdy = '0;
    if (take) begin
      in_rdy[win] = 1'b1;
    end
    cand.write = in_req[win].op inside {OP_WRITE_NOSNOOP, OP_WRITE_UNIQUE};
    cand.addr  = in_req[win].addr;
    cand.id    = {win[0], win[PTR_W-1:1], in_req[win].id};
    cand.wdata = in_req[win].wdata;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vld_q <= 1'b0;
      ptr_q <= '0;
    end else if (take) begin
      vld_q <= 1'b1;
      ptr_q <= PTR_W'((int'(win) + 1) % NI);
    end else if (mem_req_ready_i) begin
      vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      req_q <= cand;
    end
  end

  assign mem_req_valid_o = vld_q;
  assign mem_req_o       = req_q;

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  assign rsp_port        = {mem_rsp_i.id[GRP_BIT], mem_rsp_i.id[PIG_BIT]};
  assign mem_rsp_ready_o = rsp_ready_i[rsp_port];
  assign done_id_o       = mem_rsp_i.id[`CCU_ID_W:0];

  always_comb begin
    for (int p = 0; p < `CCU_NUM_PORTS; p++) begin
      rsp_valid_o[p]    = mem_rsp_valid_i && (rsp_port == PORT_W'(p));
      rsp_o[p].id       = mem_rsp_i.id[`CCU_ID_W-1:0];
      rsp_o[p].rdata    = mem_rsp_i.rdata;
    end
    // Completion at the port handshake
    for (int g = 0; g < NG; g++) begin
      done_o[g] = mem_rsp_valid_i && mem_rsp_ready_o && mem_rsp_i.id[SNP_BIT] &&
                  (mem_rsp_i.id[GRP_BIT] == 1'(g));
    end
  end

endmodule

// ==== hw/ccu_master_path.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module ccu_master_path (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic                     [`CCU_NUM_PORTS-1:0]  req_valid_i,
  input  ccu_link_pkg::cache_req_t [`CCU_NUM_PORTS-1:0]  req_i,
  output logic                     [`CCU_NUM_PORTS-1:0]  req_ready_o,
  output logic                     [`CCU_NUM_PORTS-1:0]  rsp_valid_o,
  output ccu_link_pkg::cache_rsp_t [`CCU_NUM_PORTS-1:0]  rsp_o,
  input  logic                     [`CCU_NUM_PORTS-1:0]  rsp_ready_i,
  output logic                                           mem_req_valid_o,
  output ccu_link_pkg::mem_req_t                         mem_req_o,
  input  logic                                           mem_req_ready_i,
  input  logic                                           mem_rsp_valid_i,
  input  ccu_link_pkg::mem_rsp_t                         mem_rsp_i,
  output logic                                           mem_rsp_ready_o,
  output logic                     [`CCU_NUM_GROUPS-1:0] cm_req_o,
  output ccu_txn_pkg::cm_addr_t    [`CCU_NUM_GROUPS-1:0] cm_addr_o
);

  // Router to arbiter and trackers
  logic                   [`CCU_NUM_GROUPS-1:0] nsnp_valid, nsnp_ready;
  ccu_link_pkg::grp_req_t [`CCU_NUM_GROUPS-1:0] nsnp;
  logic                   [`CCU_NUM_GROUPS-1:0] snp_valid, snp_ready;
  ccu_link_pkg::grp_req_t [`CCU_NUM_GROUPS-1:0] snp;

  // Trackers to arbiter
  logic                   [`CCU_NUM_GROUPS-1:0] trk_valid, trk_ready;
  ccu_link_pkg::grp_req_t [`CCU_NUM_GROUPS-1:0] trk;
  logic                   [`CCU_NUM_GROUPS-1:0] done;
  ccu_txn_pkg::grp_id_t                         done_id;

  ccu_port_router i_router (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .nsnp_valid_o (nsnp_valid),
    .nsnp_o       (nsnp),
    .nsnp_ready_i (nsnp_ready),
    .snp_valid_o  (snp_valid),
    .snp_o        (snp),
    .snp_ready_i  (snp_ready)
  );

  for (genvar g = 0; g < `CCU_NUM_GROUPS; g++) begin : gen_tracker
    ccu_snoop_tracker i_tracker (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_valid_i  (snp_valid[g]),
      .in_i        (snp[g]),
      .in_ready_o  (snp_ready[g]),
      .out_valid_o (trk_valid[g]),
      .out_o       (trk[g]),
      .out_ready_i (trk_ready[g]),
      .done_i      (done[g]),
      .done_id_i   (done_id),
      .cm_req_o    (cm_req_o[g]),
      .cm_addr_o   (cm_addr_o[g])
    );
  end

  ccu_mem_arbiter i_mem_arbiter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .nsnp_valid_i    (nsnp_valid),
    .nsnp_i          (nsnp),
    .nsnp_ready_o    (nsnp_ready),
    .snp_valid_i     (trk_valid),
    .snp_i           (trk),
    .snp_ready_o     (trk_ready),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_i       (mem_rsp_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_o           (rsp_o),
    .rsp_ready_i     (rsp_ready_i),
    .done_o          (done),
    .done_id_o       (done_id)
  );

endmodule

// ==== sim/ccu_master_path_chk.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module ccu_master_path_chk (
  input logic                                           clk_i,
  input logic                                           reset_i,
  input logic                                           mem_req_valid_i,
  input ccu_link_pkg::mem_req_t                         mem_req_i,
  input logic                                           mem_req_ready_i,
  input logic                     [`CCU_NUM_PORTS-1:0]  rsp_valid_i,
  input ccu_link_pkg::cache_rsp_t [`CCU_NUM_PORTS-1:0]  rsp_i,
  input logic                     [`CCU_NUM_PORTS-1:0]  rsp_ready_i,
  input logic                     [`CCU_NUM_GROUPS-1:0] cm_req_i
);
  localparam int PPG = `CCU_PORTS_PER_GROUP;

  // Failed assertion count
  int fails = 0;

  mem_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else begin
      $error("mem_req dropped or changed while stalled");
      fails++;
    end

  cm_quiet_in_reset: assert property (@(posedge clk_i) reset_i |=> cm_req_i == '0)
    else begin
      $error("cm_req_o high during or right after reset");
      fails++;
    end

  for (genvar p = 0; p < `CCU_NUM_PORTS; p++) begin : gen_rsp
    rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_valid_i[p] && !rsp_ready_i[p] |=> rsp_valid_i[p] && $stable(rsp_i[p]))
      else begin
        $error("rsp on port %0d dropped or changed while stalled", p);
        fails++;
      end
  end

  // Event follows a response handshake on a port of the same group
  for (genvar g = 0; g < `CCU_NUM_GROUPS; g++) begin : gen_cm
    cm_after_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
      cm_req_i[g] |-> $past(|(rsp_valid_i[g*PPG +: PPG] & rsp_ready_i[g*PPG +: PPG])))
      else begin
        $error("cm_req_o[%0d] without a response handshake", g);
        fails++;
      end
  end

endmodule

bind ccu_master_path ccu_master_path_chk u_chk (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_i       (mem_req_o),
  .mem_req_ready_i (mem_req_ready_i),
  .rsp_valid_i     (rsp_valid_o),
  .rsp_i           (rsp_o),
  .rsp_ready_i     (rsp_ready_i),
  .cm_req_i        (cm_req_o)
);

// ==== sim/ccu_scoreboard.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module ccu_scoreboard (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic                     [`CCU_NUM_PORTS-1:0]  req_valid_i,
  input  logic                                           mem_req_valid_i,
  input  logic                     [`CCU_NUM_PORTS-1:0]  rsp_valid_i,
  input  ccu_link_pkg::cache_rsp_t [`CCU_NUM_PORTS-1:0]  rsp_i,
  input  logic                     [`CCU_NUM_PORTS-1:0]  rsp_ready_i,
  input  logic                     [`CCU_NUM_GROUPS-1:0] cm_req_i,
  input  ccu_txn_pkg::cm_addr_t    [`CCU_NUM_GROUPS-1:0] cm_addr_i,
  output logic                                           all_done_o
);
  localparam int NT = 17;
  localparam int NP = `CCU_NUM_PORTS;

  logic [107:0] tst [NT];
  logic [NT-1:0] rsp_seen;
  logic [NT-1:0] cm_wait;
  logic started;
  int errors;
  int rsp_cnt [NP];
  int exp_cnt [NP];

  initial begin
    $readmemh("sim/ccu_testdata.hex", tst);
    for (int p = 0; p < NP; p++) begin
      exp_cnt[p] = 0;
    end
    for (int i = 0; i < NT; i++) begin
      exp_cnt[int'(tst[i][107:104])]++;
    end
  end

  // Line address as the conflict monitor reports it
  function automatic logic [`CCU_CM_ADDR_W-1:0] line_of(input logic [31:0] addr);
    return addr[`CCU_LINE_OFFSET +: `CCU_CM_ADDR_W];
  endfunction

  task automatic check_rsp(input int p);
    int hit;
    hit = -1;
    for (int i = 0; i < NT; i++) begin
      if (hit < 0 && !rsp_seen[i] && int'(tst[i][107:104]) == p &&
          tst[i][67:64] == rsp_i[p].id) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      errors++;
      $display("MISMATCH rsp_o[%0d].id: got %h, matching no outstanding request",
               p, rsp_i[p].id);
    end else begin
      rsp_seen[hit] = 1'b1;
      if (tst[hit][101]) begin
        cm_wait[hit] = 1'b1;
      end
      if (rsp_i[p].rdata !== tst[hit][31:0]) begin
        errors++;
        $display("MISMATCH rsp_o[%0d].rdata test %0d: got %h expected %h",
                 p, hit, rsp_i[p].rdata, tst[hit][31:0]);
      end else if (!tst[hit][101]) begin
        $display("test %0d port %0d id %h: ok", hit, p, rsp_i[p].id);
      end
    end
  endtask

  task automatic check_cm(input int g);
    int hit;
    int first;
    hit   = -1;
    first = -1;
    for (int i = 0; i < NT; i++) begin
      if (cm_wait[i] && int'(tst[i][107:104]) / `CCU_PORTS_PER_GROUP == g) begin
        if (first < 0) begin
          first = i;
        end
        if (hit < 0 && line_of(tst[i][99:68]) == cm_addr_i[g]) begin
          hit = i;
        end
      end
    end
    if (hit >= 0) begin
      cm_wait[hit] = 1'b0;
      $display("test %0d cm event group %0d line %h: ok", hit, g, cm_addr_i[g]);
    end else if (first >= 0) begin
      errors++;
      $display("MISMATCH cm_addr_o[%0d]: got %h expected %h",
               g, cm_addr_i[g], line_of(tst[first][99:68]));
    end else begin
      errors++;
      $display("cm_req_o[%0d] pulsed with no snooping transaction completed", g);
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      rsp_seen = '0;
      cm_wait  = '0;
      started  = 1'b0;
      errors   = 0;
      for (int p = 0; p < NP; p++) begin
        rsp_cnt[p] = 0;
      end
    end else begin
      if (!started && (mem_req_valid_i || |rsp_valid_i || |cm_req_i)) begin
        errors++;
        $display("DUT output went active before the first request");
      end
      for (int p = 0; p < NP; p++) begin
        if (rsp_valid_i[p] && rsp_ready_i[p]) begin
          rsp_cnt[p]++;
          check_rsp(p);
        end
      end
      for (int g = 0; g < `CCU_NUM_GROUPS; g++) begin
        if (cm_req_i[g]) begin
          check_cm(g);
        end
      end
      if (|req_valid_i) begin
        started = 1'b1;
      end
    end
  end

  assign all_done_o = (&rsp_seen) && (cm_wait == '0);

  task automatic final_report();
    int total;
    total = 0;
    for (int p = 0; p < NP; p++) begin
      total += rsp_cnt[p];
      if (rsp_cnt[p] != exp_cnt[p]) begin
        errors++;
        $display("MISMATCH response count port %0d: got %h expected %h",
                 p, rsp_cnt[p], exp_cnt[p]);
      end
    end
    $display("tests %0d, responses %0d, errors %0d", NT, total, errors);
  endtask

endmodule

// ==== sim/tb_ccu_master_path.sv ====
`timescale 1ns/100ps
`include "ccu_settings.svh"

module tb_ccu_master_path;
  localparam int NT    = 17;
  localparam int NP    = `CCU_NUM_PORTS;
  localparam int LIMIT = 2000;

  logic                                           clk_i;
  logic                                           reset_i;
  logic                     [NP-1:0]              req_valid_i;
  ccu_link_pkg::cache_req_t [NP-1:0]              req_i;
  logic                     [NP-1:0]              req_ready_o;
  logic                     [NP-1:0]              rsp_valid_o;
  ccu_link_pkg::cache_rsp_t [NP-1:0]              rsp_o;
  logic                     [NP-1:0]              rsp_ready_i;
  logic                                           mem_req_valid_o;
  ccu_link_pkg::mem_req_t                         mem_req_o;
  logic                                           mem_req_ready_i;
  logic                                           mem_rsp_valid_i;
  ccu_link_pkg::mem_rsp_t                         mem_rsp_i;
  logic                                           mem_rsp_ready_o;
  logic                     [`CCU_NUM_GROUPS-1:0] cm_req_o;
  ccu_txn_pkg::cm_addr_t    [`CCU_NUM_GROUPS-1:0] cm_addr_o;
  logic                                           all_done;

  logic [107:0] tst [NT];
  int           port_q [NP][$];
  logic [31:0]  mem [logic [31:0]];
  ccu_link_pkg::mem_rsp_t rsp_q [$];

  ccu_master_path DUT (.*);

  ccu_scoreboard u_scoreboard (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .mem_req_valid_i (mem_req_valid_o),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_i           (rsp_o),
    .rsp_ready_i     (rsp_ready_i),
    .cm_req_i        (cm_req_o),
    .cm_addr_i       (cm_addr_o),
    .all_done_o      (all_done)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Memory model with random back-pressure
  ////////////////////////////////////////////////////////////

  initial begin
    ccu_link_pkg::mem_rsp_t r;
    logic busy;
    int   delay;
    mem_req_ready_i = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_i       = '0;
    rsp_ready_i     = '0;
    busy            = 1'b0;
    delay           = 0;
    forever begin
      @(posedge clk_i);
      if (reset_i) begin
        busy = 1'b0;
        rsp_q.delete();
        mem_rsp_valid_i <= 1'b0;
      end else begin
        if (mem_req_valid_o && mem_req_ready_i) begin
          r.id = mem_req_o.id;
          if (mem_req_o.write) begin
            mem[mem_req_o.addr] = mem_req_o.wdata;
            r.rdata = '0;
          end else begin
            r.rdata = mem.exists(mem_req_o.addr) ? mem[mem_req_o.addr] : '0;
          end
          rsp_q.push_back(r);
        end
        if (busy && mem_rsp_ready_o) begin
          busy  = 1'b0;
          delay = int'($urandom % 4);
          mem_rsp_valid_i <= 1'b0;
        end else if (!busy && rsp_q.size() > 0) begin
          if (delay > 0) begin
            delay--;
          end else begin
            busy = 1'b1;
            mem_rsp_i       <= rsp_q.pop_front();
            mem_rsp_valid_i <= 1'b1;
          end
        end
      end
      mem_req_ready_i <= ($urandom % 3) != 0;
      rsp_ready_i     <= NP'($urandom);
    end
  end

  ////////////////////////////////////////////////////////////
  // Request driver and end of run
  ////////////////////////////////////////////////////////////

  initial begin
    ccu_link_pkg::cache_req_t c;
    logic [NP-1:0] vld;
    int   cyc;
    int   idx;
    logic timed_out;
    req_valid_i = '0;
    req_i       = '0;
    reset_i     = 1'b1;
    vld         = '0;
    timed_out   = 1'b0;
    void'($urandom(32'he95b));
    $readmemh("sim/ccu_testdata.hex", tst);
    for (int i = 0; i < NT; i++) begin
      port_q[int'(tst[i][107:104])].push_back(i);
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    // Idle stretch for the post-reset checks
    repeat (4) @(posedge clk_i);

    cyc = 0;
    while (cyc < LIMIT && (vld != '0 || port_q[0].size() + port_q[1].size() +
                           port_q[2].size() + port_q[3].size() > 0)) begin
      @(posedge clk_i);
      cyc++;
      for (int p = 0; p < NP; p++) begin
        if (vld[p] && req_ready_o[p]) begin
          vld[p] = 1'b0;
        end
        if (!vld[p] && port_q[p].size() > 0 && ($urandom % 2) == 0) begin
          idx     = port_q[p].pop_front();
          c.op    = ccu_txn_pkg::ccu_op_e'(tst[idx][101:100]);
          c.addr  = tst[idx][99:68];
          c.id    = tst[idx][67:64];
          c.wdata = tst[idx][63:32];
          req_i[p] <= c;
          vld[p]   = 1'b1;
        end
      end
      req_valid_i <= vld;
    end
    if (cyc >= LIMIT) begin
      timed_out = 1'b1;
      $display("timeout: the DUT never accepted all requests");
    end

    cyc = 0;
    while (!timed_out && !all_done && cyc < LIMIT) begin
      @(posedge clk_i);
      cyc++;
    end
    if (!timed_out && !all_done) begin
      timed_out = 1'b1;
      $display("timeout: responses or conflict-monitor events never arrived");
    end
    repeat (3) @(posedge clk_i);

    u_scoreboard.final_report();
    if (!timed_out && u_scoreboard.errors == 0 && DUT.u_chk.fails == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== ccu_master_path.f ====
+incdir+hw
hw/ccu_txn_pkg.sv
hw/ccu_link_pkg.sv
hw/ccu_port_router.sv
hw/ccu_snoop_tracker.sv
hw/ccu_mem_arbiter.sv
hw/ccu_master_path.sv
sim/ccu_master_path_chk.sv
sim/ccu_scoreboard.sv
sim/tb_ccu_master_path.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f ccu_master_path.f \
  --top-module tb_ccu_master_path -o sim_tb

# The log is judged below, so a stopped run still reaches the search
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  exit 1
fi

// ==== sim/ccu_testdata.hex ====
// port _ op _ addr _ id _ wdata _ expected rdata
// op: 0 read, 1 write, 2 read shared (snoop), 3 write unique (snoop)
0_3_00000100_1_11111111_00000000
0_2_00000100_2_00000000_11111111
0_2_00000200_3_00000000_00000000
0_3_00000300_4_33333333_00000000
1_3_00001100_1_44444444_00000000
1_2_00001100_2_00000000_44444444
1_2_00001200_3_00000000_00000000
1_3_00001340_4_55555555_00000000
0_2_00000300_5_00000000_33333333
2_1_00002000_1_66666666_00000000
2_0_00002000_2_00000000_66666666
2_2_00002400_3_00000000_00000000
3_0_00003000_1_00000000_00000000
3_1_00003010_2_77777777_00000000
3_0_00003010_3_00000000_77777777
3_3_00003ff0_4_88888888_00000000
1_0_00001500_5_00000000_00000000
